//--- verilog.f
+incdir+testbench
source/aesKeyPkg.sv
source/sboxLookup.sv
source/keyLoader.sv
source/roundKeyGenerator.sv
source/keyScheduleStore.sv
source/keyExpansionTop.sv
testbench/keyExpansionTb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps -f verilog.f --top-module keyExpansionTb
./obj_dir/VkeyExpansionTb > sim.log 2>&1 || true
cat sim.log

if grep -q "sim passed" sim.log; then
	exit 0
fi
exit 1

//--- testbench/aesRefModel.svh
`ifndef AES_REF_MODEL_SVH
`define AES_REF_MODEL_SVH

// FIPS-197 forward S-box, entry 0 in the top byte
localparam logic [2047:0] sboxTable = {
	128'h637c777bf26b6fc53001672bfed7ab76,
	128'hca82c97dfa5947f0add4a2af9ca472c0,
	128'hb7fd9326363ff7cc34a5e5f171d83115,
	128'h04c723c31896059a071280e2eb27b275,
	128'h09832c1a1b6e5aa0523bd6b329e32f84,
	128'h53d100ed20fcb15b6acbbe394a4c58cf,
	128'hd0efaafb434d338545f9027f503c9fa8,
	128'h51a3408f929d38f5bcb6da2110fff3d2,
	128'hcd0c13ec5f974417c4a77e3d645d1973,
	128'h60814fdc222a908846eeb814de5e0bdb,
	128'he0323a0a4906245cc2d3ac629195e479,
	128'he7c8376d8dd54ea96c56f4ea657aae08,
	128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
	128'h703eb5664803f60e613557b986c11d9e,
	128'he1f8981169d98e949b1e87e9ce5528df,
	128'h8ca1890dbfe6426841992d0fb054bb16
};

localparam logic [79:0] rconTable = 80'h01020408102040801b36; // rounds 1 to 10

logic [31:0] lcgState = 32'hcce0a283;

function automatic logic [7:0] sboxByte(input logic [7:0] value);
	int idx;
	begin
		idx = int'(value);
		sboxByte = sboxTable[2047 - 8 * idx -: 8];
	end
endfunction

// key schedule as word array w[0..43]
function automatic logic [1407:0] expandKeyRef(input logic [127:0] key);
	logic [31:0] w [0:43];
	logic [31:0] temp;
	logic [31:0] rot;
	logic [1407:0] result;
	begin
		for (int i = 0; i < 4; i++)
			w[i] = key[127 - 32 * i -: 32];
		for (int i = 4; i < 44; i++)
		begin
			temp = w[i - 1];
			if (i % 4 == 0)
			begin
				rot = {temp[23:0], temp[31:24]};
				temp = {sboxByte(rot[31:24]), sboxByte(rot[23:16]),
					sboxByte(rot[15:8]), sboxByte(rot[7:0])};
				temp[31:24] = temp[31:24] ^ rconTable[79 - 8 * (i / 4 - 1) -: 8];
			end
			w[i] = w[i - 4] ^ temp;
		end
		for (int i = 0; i < 44; i++)
			result[1407 - 32 * i -: 32] = w[i];
		expandKeyRef = result;
	end
endfunction

function automatic logic [31:0] nextRandom();
	begin
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		nextRandom = lcgState;
	end
endfunction

`endif

//--- testbench/keyExpansionTb.sv
`timescale 1ns/1ps

module keyExpansionTb;

	logic clock;
	logic reset;
	logic start;
	aesKeyPkg::aesKey128 cipherKey;
	aesKeyPkg::expandedKey keyExp;
	logic keyExpDone;

	int errorCount = 0;
	int checkCount = 0;
	string nameQueue[$];
	logic [1407:0] expectQueue[$];
	logic [1407:0] actualQueue[$];

	`include "aesRefModel.svh"

	keyExpansionTop uut (
		.clock(clock),
		.reset(reset),
		.start(start),
		.cipherKey(cipherKey),
		.keyExp(keyExp),
		.keyExpDone(keyExpDone)
	);

	initial clock = 1'b0;
	always #5 clock = ~clock; // 10 ns period

	//////////////////////////////
	// helpers

	// values are captured on the falling edge, compared later
	task automatic queueCheck(input string name, input logic [1407:0] expected,
		input logic [1407:0] actual);
		begin
			nameQueue.push_back(name);
			expectQueue.push_back(expected);
			actualQueue.push_back(actual);
		end
	endtask

	function automatic aesKeyPkg::aesKey128 randomKey();
		aesKeyPkg::aesKey128 key;
		begin
			for (int k = 0; k < 4; k++)
				key[127 - 32 * k -: 32] = nextRandom();
			randomKey = key;
		end
	endfunction

	// called on a falling edge, returns once the load beat is taken
	task automatic pulseStart(input aesKeyPkg::aesKey128 key);
		begin
			start = 1'b1;
			cipherKey = key;
			@(negedge clock);
			start = 1'b0;
			@(negedge clock);
		end
	endtask

	task automatic waitDone(input string name, output logic seen);
		int cycles;
		begin
			cycles = 0;
			while (!keyExpDone && cycles < 100)
			begin
				@(negedge clock);
				cycles++;
			end
			seen = keyExpDone;
			if (!seen)
			begin
				$display("%s: timeout, keyExpDone did not rise within 100 cycles", name);
				errorCount++;
			end
		end
	endtask

	task automatic runExpansion(input string name, input aesKeyPkg::aesKey128 key);
		logic seen;
		begin
			pulseStart(key);
			waitDone(name, seen);
			if (seen)
				queueCheck(name, expandKeyRef(key), keyExp);
		end
	endtask

	//////////////////////////////
	// compare

	always @(posedge clock)
	begin : compareProcess
		string name;
		logic [1407:0] expected;
		logic [1407:0] actual;
		while (nameQueue.size() > 0)
		begin
			name = nameQueue.pop_front();
			expected = expectQueue.pop_front();
			actual = actualQueue.pop_front();
			checkCount++;
			if (expected !== actual)
			begin
				$display("CHECK FAILED %s: expected %0h, actual %0h", name, expected, actual);
				errorCount++;
			end
		end
	end

	//////////////////////////////
	// stimulus

	initial
	begin
		aesKeyPkg::aesKey128 key;
		logic seen;
		int cycles;
		reset = 1'b1;
		start = 1'b0;
		cipherKey = '0;
		repeat (5) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;

		queueCheck("reset done", '0, {1407'b0, keyExpDone});
		queueCheck("reset keyExp", '0, keyExp);

		key = 128'h000102030405060708090a0b0c0d0e0f;
		runExpansion("fips vector", key);
		queueCheck("fips last round", {1280'b0, 128'h13111d7fe3944a17f307a78b4d2b30c5},
			{1280'b0, keyExp[127:0]});

		for (int n = 0; n < 20; n++)
			runExpansion($sformatf("random key %0d", n), randomKey());

		// done still high from the last run
		key = randomKey();
		pulseStart(key);
		queueCheck("done clears on start", '0, {1407'b0, keyExpDone});
		waitDone("done rises again", seen);
		if (seen)
			queueCheck("done rises again", expandKeyRef(key), keyExp);

		// second start four cycles in
		pulseStart(randomKey());
		repeat (2) @(negedge clock);
		runExpansion("restart mid-run", randomKey());

		// reset three cycles into a run
		pulseStart(randomKey());
		@(negedge clock);
		reset = 1'b1;
		repeat (2) @(negedge clock);
		reset = 1'b0;
		queueCheck("reset mid-run keyExp", '0, keyExp);
		for (int n = 0; n < 30; n++)
		begin
			queueCheck("no done after reset", '0, {1407'b0, keyExpDone});
			@(negedge clock);
		end

		cycles = 0;
		while (nameQueue.size() > 0 && cycles < 10)
		begin
			@(negedge clock);
			cycles++;
		end
		if (nameQueue.size() > 0)
		begin
			$display("checks were still pending at the end of the run");
			errorCount++;
		end

		$display("checks: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

//--- source/keyExpansionTop.sv
`timescale 1ns/1ps

module keyExpansionTop (
	input logic clock,
	input logic reset,
	input logic start,
	input aesKeyPkg::aesKey128 cipherKey,
	output aesKeyPkg::expandedKey keyExp,
	output logic keyExpDone
);

	aesKeyPkg::loadBeat load;
	aesKeyPkg::roundBeat round;

	//////////////////////////////
	// input side

	keyLoader loader (
		.clock(clock),
		.reset(reset),
		.start(start),
		.cipherKey(cipherKey),
		.load(load)
	);

	//////////////////////////////
	// round keys, one per cycle

	roundKeyGenerator generator (
		.clock(clock),
		.reset(reset),
		.load(load),
		.round(round)
	);

	//////////////////////////////
	// output side

	keyScheduleStore store (
		.clock(clock),
		.reset(reset),
		.load(load),
		.round(round),
		.keyExp(keyExp),
		.keyExpDone(keyExpDone)
	);

endmodule

//--- source/keyScheduleStore.sv
`timescale 1ns/1ps

module keyScheduleStore (
	input logic clock,
	input logic reset,
	input aesKeyPkg::loadBeat load,
	input aesKeyPkg::roundBeat round,
	output aesKeyPkg::expandedKey keyExp,
	output logic keyExpDone
);

	aesKeyPkg::expandedKey keyExpReg;
	logic doneReg;
	logic [10:0] roundSlot; // lsb of the slot for round.index
	logic lastRound;

	// round 0 on top, so slot lsb is (10 - index) * 128
	assign roundSlot = {aesKeyPkg::numRounds - round.index, 7'd0};
	assign lastRound = round.valid && (round.index == aesKeyPkg::numRounds);

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			keyExpReg <= '0;
			doneReg <= 1'b0;
		end
		else if (load.valid)
		begin
			// new key, old rounds are overwritten as they come
			keyExpReg[$bits(aesKeyPkg::expandedKey) - 1 -: 128] <= load.key;
			doneReg <= 1'b0;
		end
		else if (round.valid)
		begin
			keyExpReg[roundSlot +: 128] <= round.key;
			if (lastRound)
				doneReg <= 1'b1;
		end
	end

	assign keyExp = keyExpReg;
	assign keyExpDone = doneReg;

	doneAfterLastRound: assert property (@(posedge clock) disable iff (reset)
		$rose(keyExpDone) |-> $past(lastRound));

endmodule

//--- source/roundKeyGenerator.sv
`timescale 1ns/1ps

module roundKeyGenerator (
	input logic clock,
	input logic reset,
	input aesKeyPkg::loadBeat load,
	output aesKeyPkg::roundBeat round
);

	aesKeyPkg::genState state;
	aesKeyPkg::roundIndex count; // round held in keyReg
	aesKeyPkg::rconByte rcon;
	aesKeyPkg::rconByte rconNext;
	aesKeyPkg::aesKey128 keyReg;
	aesKeyPkg::aesKey128 nextKey;
	logic roundValid;
	logic advance;

	aesKeyPkg::word32 lastWord;
	aesKeyPkg::word32 rotWord;
	aesKeyPkg::word32 subWord;
	aesKeyPkg::word32 newWord0;
	aesKeyPkg::word32 newWord1;
	aesKeyPkg::word32 newWord2;
	aesKeyPkg::word32 newWord3;

	//////////////////////////////
	// one full round per cycle

	assign lastWord = keyReg[31:0];
	assign rotWord = {lastWord[23:0], lastWord[31:24]}; // RotWord

	sboxLookup sbox (
		.inWord(rotWord),
		.outWord(subWord)
	);

	// running XOR chain over the previous round key
	assign newWord0 = keyReg[127:96] ^ subWord ^ {rcon, 24'h000000};
	assign newWord1 = keyReg[95:64] ^ newWord0;
	assign newWord2 = keyReg[63:32] ^ newWord1;
	assign newWord3 = keyReg[31:0] ^ newWord2;
	assign nextKey = {newWord0, newWord1, newWord2, newWord3};

	// xtime on the round constant
	assign rconNext = {rcon[6:0], 1'b0} ^ (rcon[7] ? aesKeyPkg::rconWrap : 8'h00);

	assign advance = (state == aesKeyPkg::genRun) && (count != aesKeyPkg::numRounds);

	//////////////////////////////
	// FSM

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			state <= aesKeyPkg::genIdle;
			count <= '0;
			rcon <= aesKeyPkg::rconFirst;
			roundValid <= 1'b0;
		end
		else if (load.valid)
		begin
			// also restarts a running schedule
			state <= aesKeyPkg::genRun;
			count <= '0;
			rcon <= aesKeyPkg::rconFirst;
			roundValid <= 1'b0;
		end
		else
		begin
			case (state)
				aesKeyPkg::genIdle:
				begin
					roundValid <= 1'b0;
				end
				aesKeyPkg::genRun:
				begin
					if (advance)
					begin
						count <= count + 4'd1;
						rcon <= rconNext;
						roundValid <= 1'b1;
					end
					else
					begin
						state <= aesKeyPkg::genIdle; // round 10 already out
						roundValid <= 1'b0;
					end
				end
			endcase
		end
	end

	always_ff @(posedge clock)
	begin
		if (load.valid)
			keyReg <= load.key; // round 0
		else if (advance)
			keyReg <= nextKey;
	end

	assign round = '{valid: roundValid, index: count, key: keyReg};

	indexInRange: assert property (@(posedge clock) disable iff (reset)
		round.index <= aesKeyPkg::numRounds);

	quietWhenIdle: assert property (@(posedge clock) disable iff (reset)
		(state == aesKeyPkg::genIdle) |-> !round.valid);

endmodule

//--- source/keyLoader.sv
`timescale 1ns/1ps

module keyLoader (
	input logic clock,
	input logic reset,
	input logic start,
	input aesKeyPkg::aesKey128 cipherKey,
	output aesKeyPkg::loadBeat load
);

	logic loadValid;
	aesKeyPkg::aesKey128 loadKey;

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			loadValid <= 1'b0;
		end
		else
		begin
			loadValid <= start; // one beat per strobe
		end
	end

	// held until the next strobe so the inputs may move
	always_ff @(posedge clock)
	begin
		if (start)
			loadKey <= cipherKey;
	end

	assign load = '{valid: loadValid, key: loadKey};

	loadSingleBeat: assert property (@(posedge clock) disable iff (reset)
		load.valid |=> !load.valid);

endmodule

//--- source/sboxLookup.sv
`timescale 1ns/1ps

module sboxLookup (
	input aesKeyPkg::word32 inWord,
	output aesKeyPkg::word32 outWord
);

	// forward S-box, one row of 16 bytes per high nibble
	function automatic logic [7:0] subByte(input logic [7:0] inByte);
		logic [127:0] row;
		begin
			case (inByte[7:4])
				4'h0: row = {64'h637c777bf26b6fc5,
					64'h3001672bfed7ab76};
				4'h1: row = {64'hca82c97dfa5947f0,
					64'hadd4a2af9ca472c0};
				4'h2: row = {64'hb7fd9326363ff7cc,
					64'h34a5e5f171d83115};
				4'h3: row = {64'h04c723c31896059a,
					64'h071280e2eb27b275};
				4'h4: row = {64'h09832c1a1b6e5aa0,
					64'h523bd6b329e32f84};
				4'h5: row = {64'h53d100ed20fcb15b,
					64'h6acbbe394a4c58cf};
				4'h6: row = {64'hd0efaafb434d3385,
					64'h45f9027f503c9fa8};
				4'h7: row = {64'h51a3408f929d38f5,
					64'hbcb6da2110fff3d2};
				4'h8: row = {64'hcd0c13ec5f974417,
					64'hc4a77e3d645d1973};
				4'h9: row = {64'h60814fdc222a9088,
					64'h46eeb814de5e0bdb};
				4'ha: row = {64'he0323a0a4906245c,
					64'hc2d3ac629195e479};
				4'hb: row = {64'he7c8376d8dd54ea9,
					64'h6c56f4ea657aae08};
				4'hc: row = {64'hba78252e1ca6b4c6,
					64'he8dd741f4bbd8b8a};
				4'hd: row = {64'h703eb5664803f60e,
					64'h613557b986c11d9e};
				4'he: row = {64'he1f8981169d98e94,
					64'h9b1e87e9ce5528df};
				4'hf: row = {64'h8ca1890dbfe64268,
					64'h41992d0fb054bb16};
			endcase
			// column 0 sits in the top byte of the row
			subByte = row[{~inByte[3:0], 3'b000} +: 8];
		end
	endfunction

	// four independent lookups
	always_comb
	begin
		for (int b = 0; b < 4; b++)
		begin
			outWord[b * 8 +: 8] = subByte(inWord[b * 8 +: 8]);
		end
	end

endmodule

//--- source/aesKeyPkg.sv
package aesKeyPkg;

	//////////////////////////////
	// widths

	typedef logic [31:0] word32; // one schedule word
	typedef logic [127:0] aesKey128; // cipher key or one round key
	typedef logic [1407:0] expandedKey; // eleven round keys, round 0 on top
	typedef logic [3:0] roundIndex;
	typedef logic [7:0] rconByte;

	//////////////////////////////
	// AES-128 constants

	localparam roundIndex numRounds = 4'd10;
	localparam rconByte rconFirst = 8'h01;
	localparam rconByte rconWrap = 8'h1b; // follows 8'h80 in GF(2^8)

	//////////////////////////////
	// beats between the blocks

	// key captured on start, one cycle wide
	typedef struct packed
	{
		logic valid;
		aesKey128 key;
	} loadBeat;

	// one finished round key
	typedef struct packed
	{
		logic valid;
		roundIndex index;
		aesKey128 key;
	} roundBeat;

	// generator FSM
	typedef enum logic
	{
		genIdle,
		genRun
	} genState;

endpackage
